// File: include/cu_config.svh
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Instruction field widths
`define CU_OPCODE_W 6
`define CU_FUNCT_W  6
`define CU_STEP_W   2

`define CU_OPCODE_RTYPE 6'h00

// R-type funct codes
`define CU_FUNCT_ADD   6'h20
`define CU_FUNCT_SUB   6'h22
`define CU_FUNCT_AND   6'h24
`define CU_FUNCT_XCHG  6'h05
`define CU_FUNCT_RTE   6'h13
`define CU_FUNCT_BREAK 6'h0D

`define CU_ALUOP_NONE 3'd0
`define CU_ALUOP_ADD  3'd1
`define CU_ALUOP_SUB  3'd2
`define CU_ALUOP_AND  3'd3

`define CU_SRCB_REGB 2'd0
`define CU_SRCB_FOUR 2'd1

`define CU_PCSRC_ALU 3'd0
`define CU_PCSRC_EPC 3'd1

`define CU_REGDST_RT 3'd0
`define CU_REGDST_RS 3'd1
`define CU_REGDST_RD 3'd3

// One-hot write-back source select
`define CU_WB_REGA   4'd1
`define CU_WB_ALUOUT 4'd2
`define CU_WB_REGB   4'd4

`define CU_FETCH_STEPS 4

`endif

// File: source/cu_pkg.sv
package cu_pkg;

  // Instruction fields
  typedef logic [5:0] opcode_t;
  typedef logic [5:0] funct_t;

  // Cycle index inside fetch or an execute sequence
  typedef logic [1:0] step_t;

  // Control field vectors
  typedef logic [2:0] aluop_t;
  typedef logic [1:0] srcb_t;
  typedef logic [2:0] pcsrc_t;
  typedef logic [2:0] regdst_t;
  typedef logic [3:0] wbsel_t;

  typedef enum logic [2:0] {
    ST_FETCH = 3'd0,
    ST_ADD   = 3'd1,
    ST_SUB   = 3'd2,
    ST_AND   = 3'd3,
    ST_XCHG  = 3'd4,
    ST_RTE   = 3'd5,
    ST_BREAK = 3'd6
  } cu_state_e;

  typedef struct packed {
    logic   srca;
    srcb_t  srcb;
    aluop_t aluop;
  } alu_ctrl_t;

  typedef struct packed {
    pcsrc_t pcsource;
    logic   pcwrite;
  } pc_ctrl_t;

  typedef struct packed {
    regdst_t regdst;
    wbsel_t  wbsel;
    logic    regwrite;
  } rf_ctrl_t;

  // Load enables for IR and the A, B and ALUOut latches
  typedef struct packed {
    logic irwrite;
    logic rega;
    logic regb;
    logic aluout;
  } latch_ctrl_t;

  typedef struct packed {
    alu_ctrl_t   alu;
    pc_ctrl_t    pc;
    rf_ctrl_t    rf;
    latch_ctrl_t latch;
  } ctrl_word_t;

endpackage

// File: source/cu_decoder.sv
`timescale 1ns/1ps
`include "cu_config.svh"

module cu_decoder (
  input  cu_pkg::opcode_t   opcode,
  input  cu_pkg::funct_t    funct,
  output cu_pkg::cu_state_e next_state
);

  import cu_pkg::*;

  always_comb begin
    next_state = ST_FETCH;
    case (opcode)
      `CU_OPCODE_RTYPE: begin
        case (funct)
          `CU_FUNCT_ADD: begin
            next_state = ST_ADD;
          end
          `CU_FUNCT_SUB: begin
            next_state = ST_SUB;
          end
          `CU_FUNCT_AND: begin
            next_state = ST_AND;
          end
          `CU_FUNCT_XCHG: begin
            next_state = ST_XCHG;
          end
          `CU_FUNCT_RTE: begin
            next_state = ST_RTE;
          end
          `CU_FUNCT_BREAK: begin
            next_state = ST_BREAK;
          end
          // Unsupported funct restarts fetch
          default: begin
            next_state = ST_FETCH;
          end
        endcase
      end
      default: begin
        next_state = ST_FETCH;
      end
    endcase
  end

endmodule

// File: source/cu_sequencer.sv
`timescale 1ns/1ps

module cu_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  cu_pkg::cu_state_e next_state,
  output cu_pkg::cu_state_e state,
  output cu_pkg::step_t     step
);

  import cu_pkg::*;

  step_t last_step;
  logic  at_last;

  // Final step index of each sequence
  function automatic step_t seq_last_step(cu_state_e s);
    case (s)
      ST_FETCH: begin
        return step_t'(3);
      end
      ST_ADD, ST_SUB, ST_AND: begin
        return step_t'(2);
      end
      ST_XCHG: begin
        return step_t'(2);
      end
      ST_RTE, ST_BREAK: begin
        return step_t'(0);
      end
      default: begin
        return step_t'(0);
      end
    endcase
  endfunction

  assign last_step = seq_last_step(state);
  assign at_last   = (step == last_step);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      step  <= '0;
    end else if (at_last) begin
      // Decode cycle picks the execute sequence, execute ends go back to fetch
      if (state == ST_FETCH) begin
        state <= next_state;
      end else begin
        state <= ST_FETCH;
      end
      step <= '0;
    end else begin
      step <= step + step_t'(1);
    end
  end

endmodule

// File: source/cu_control_table.sv
`timescale 1ns/1ps
`include "cu_config.svh"

module cu_control_table (
  input  logic               clk,
  input  logic               reset,
  input  cu_pkg::cu_state_e  state,
  input  cu_pkg::step_t      step,
  output cu_pkg::ctrl_word_t ctrl
);

  import cu_pkg::*;

  localparam step_t DECODE_STEP = step_t'(`CU_FETCH_STEPS - 1);

  ctrl_word_t entry;

  // ALU operation for the arithmetic states
  function automatic aluop_t state_aluop(cu_state_e s);
    case (s)
      ST_ADD:  return `CU_ALUOP_ADD;
      ST_SUB:  return `CU_ALUOP_SUB;
      ST_AND:  return `CU_ALUOP_AND;
      default: return `CU_ALUOP_NONE;
    endcase
  endfunction

  always_comb begin
    entry = '0;
    case (state)
      ST_FETCH: begin
        // PC+4 runs through the ALU until decode
        if (step != DECODE_STEP) begin
          entry.alu.srcb  = `CU_SRCB_FOUR;
          entry.alu.aluop = `CU_ALUOP_ADD;
        end
        if (step == step_t'(2)) begin
          entry.latch.irwrite = 1'b1;
          entry.pc.pcwrite    = 1'b1;
        end
      end
      ST_ADD, ST_SUB, ST_AND: begin
        case (step)
          step_t'(0): begin
            entry.latch.rega = 1'b1;
            entry.latch.regb = 1'b1;
          end
          step_t'(1): begin
            entry.alu.srca      = 1'b1;
            entry.alu.srcb      = `CU_SRCB_REGB;
            entry.alu.aluop     = state_aluop(state);
            entry.latch.aluout  = 1'b1;
          end
          step_t'(2): begin
            entry.rf.regdst   = `CU_REGDST_RD;
            entry.rf.wbsel    = `CU_WB_ALUOUT;
            entry.rf.regwrite = 1'b1;
          end
          default: ;
        endcase
      end
      ST_XCHG: begin
        case (step)
          step_t'(0): begin
            entry.latch.rega = 1'b1;
            entry.latch.regb = 1'b1;
          end
          step_t'(1): begin
            entry.rf.regdst   = `CU_REGDST_RT;
            entry.rf.wbsel    = `CU_WB_REGB;
            entry.rf.regwrite = 1'b1;
          end
          step_t'(2): begin
            entry.rf.regdst   = `CU_REGDST_RS;
            entry.rf.wbsel    = `CU_WB_REGA;
            entry.rf.regwrite = 1'b1;
          end
          default: ;
        endcase
      end
      ST_RTE: begin
        entry.pc.pcsource = `CU_PCSRC_EPC;
        entry.pc.pcwrite  = 1'b1;
      end
      ST_BREAK: begin
        // PC-4 undoes the fetch increment
        entry.alu.srcb    = `CU_SRCB_FOUR;
        entry.alu.aluop   = `CU_ALUOP_SUB;
        entry.pc.pcsource = `CU_PCSRC_ALU;
        entry.pc.pcwrite  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl <= '0;
    end else begin
      ctrl <= entry;
    end
  end

endmodule

// File: source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  logic                clk,
  input  logic                reset,
  input  cu_pkg::opcode_t     opcode,
  input  cu_pkg::funct_t      funct,
  output cu_pkg::alu_ctrl_t   alu,
  output cu_pkg::pc_ctrl_t    pc,
  output cu_pkg::rf_ctrl_t    rf,
  output cu_pkg::latch_ctrl_t latch
);

  import cu_pkg::*;

  cu_state_e  next_state;
  cu_state_e  state;
  step_t      step;
  ctrl_word_t ctrl;

  cu_decoder u_decoder (
    .opcode     (opcode),
    .funct      (funct),
    .next_state (next_state)
  );

  cu_sequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .next_state (next_state),
    .state      (state),
    .step       (step)
  );

  cu_control_table u_control_table (
    .clk   (clk),
    .reset (reset),
    .state (state),
    .step  (step),
    .ctrl  (ctrl)
  );

  // Registered control word split into its groups
  assign alu   = ctrl.alu;
  assign pc    = ctrl.pc;
  assign rf    = ctrl.rf;
  assign latch = ctrl.latch;

endmodule

// File: dv/control_unit_tb.sv
`timescale 1ns/1ps
`include "cu_config.svh"

module control_unit_tb;

  import cu_pkg::*;

  localparam int RESET_CYCLES  = 8;
  localparam int MAX_INSTRS    = 40;
  localparam int MAX_CYCLES    = RESET_CYCLES + MAX_INSTRS * 7 + 112;
  localparam int RANDOM_INSTRS = 30;

  logic        clk;
  logic        reset;
  opcode_t     opcode;
  funct_t      funct;
  alu_ctrl_t   alu;
  pc_ctrl_t    pc;
  rf_ctrl_t    rf;
  latch_ctrl_t latch;

  // Expected word for the sequencer cycle, then one cycle later for the outputs
  ctrl_word_t  seq_exp;
  int          seq_tag;
  logic        seq_last;
  logic        seq_valid;
  ctrl_word_t  out_exp;
  int          out_tag;
  logic        out_last;
  logic        out_valid;

  string       test_names [16];
  int          test_checks [16];
  int          test_errs [16];
  int          cur_tag;
  int          cycles;

  control_unit u_control_unit (
    .clk    (clk),
    .reset  (reset),
    .opcode (opcode),
    .funct  (funct),
    .alu    (alu),
    .pc     (pc),
    .rf     (rf),
    .latch  (latch)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic cu_state_e instr_kind(opcode_t op, funct_t fn);
    if (op != `CU_OPCODE_RTYPE) begin
      return ST_FETCH;
    end
    case (fn)
      `CU_FUNCT_ADD:   return ST_ADD;
      `CU_FUNCT_SUB:   return ST_SUB;
      `CU_FUNCT_AND:   return ST_AND;
      `CU_FUNCT_XCHG:  return ST_XCHG;
      `CU_FUNCT_RTE:   return ST_RTE;
      `CU_FUNCT_BREAK: return ST_BREAK;
      default:         return ST_FETCH;
    endcase
  endfunction

  // Whole instruction length in cycles, fetch included
  function automatic int instr_len(opcode_t op, funct_t fn);
    case (instr_kind(op, fn))
      ST_ADD, ST_SUB, ST_AND, ST_XCHG: return `CU_FETCH_STEPS + 3;
      ST_RTE, ST_BREAK:                return `CU_FETCH_STEPS + 1;
      default:                         return `CU_FETCH_STEPS;
    endcase
  endfunction

  function automatic ctrl_word_t expected_word(opcode_t op, funct_t fn, int idx);
    ctrl_word_t w;
    cu_state_e  kind;
    int         ex_step;
    w = '0;
    kind = instr_kind(op, fn);
    ex_step = idx - `CU_FETCH_STEPS;
    if (idx < `CU_FETCH_STEPS) begin
      if (idx < 3) begin
        w.alu.srcb  = `CU_SRCB_FOUR;
        w.alu.aluop = `CU_ALUOP_ADD;
      end
      if (idx == 2) begin
        w.latch.irwrite = 1'b1;
        w.pc.pcwrite    = 1'b1;
      end
    end else begin
      case (kind)
        ST_ADD, ST_SUB, ST_AND: begin
          if (ex_step == 0) begin
            w.latch.rega = 1'b1;
            w.latch.regb = 1'b1;
          end else if (ex_step == 1) begin
            w.alu.srca   = 1'b1;
            w.alu.srcb   = `CU_SRCB_REGB;
            w.alu.aluop  = (kind == ST_ADD) ? `CU_ALUOP_ADD :
                           (kind == ST_SUB) ? `CU_ALUOP_SUB : `CU_ALUOP_AND;
            w.latch.aluout = 1'b1;
          end else begin
            w.rf.regdst   = `CU_REGDST_RD;
            w.rf.wbsel    = `CU_WB_ALUOUT;
            w.rf.regwrite = 1'b1;
          end
        end
        ST_XCHG: begin
          if (ex_step == 0) begin
            w.latch.rega = 1'b1;
            w.latch.regb = 1'b1;
          end else begin
            w.rf.regdst   = (ex_step == 1) ? `CU_REGDST_RT : `CU_REGDST_RS;
            w.rf.wbsel    = (ex_step == 1) ? `CU_WB_REGB : `CU_WB_REGA;
            w.rf.regwrite = 1'b1;
          end
        end
        ST_RTE: begin
          w.pc.pcsource = `CU_PCSRC_EPC;
          w.pc.pcwrite  = 1'b1;
        end
        ST_BREAK: begin
          w.alu.srcb    = `CU_SRCB_FOUR;
          w.alu.aluop   = `CU_ALUOP_SUB;
          w.pc.pcsource = `CU_PCSRC_ALU;
          w.pc.pcwrite  = 1'b1;
        end
        default: ;
      endcase
    end
    return w;
  endfunction

  task automatic push_cycle(input ctrl_word_t word, input int tag, input logic last,
                            input logic valid);
    out_exp   <= seq_exp;
    out_tag   <= seq_tag;
    out_last  <= seq_last;
    out_valid <= seq_valid;
    seq_exp   <= word;
    seq_tag   <= tag;
    seq_last  <= last;
    seq_valid <= valid;
  endtask

  // Called right after the edge where fetch step 0 of this instruction begins
  task automatic run_instr(input opcode_t op, input funct_t fn, input logic last_of_test);
    int len;
    len = instr_len(op, fn);
    opcode <= op;
    funct  <= fn;
    for (int i = 0; i < len; i++) begin
      push_cycle(expected_word(op, fn, i), cur_tag, last_of_test && (i == len - 1), 1'b1);
      @(posedge clk);
    end
  endtask

  task automatic pick_random_instr(output opcode_t op, output funct_t fn);
    int pick;
    pick = int'($urandom % 8);
    op = `CU_OPCODE_RTYPE;
    case (pick)
      0:       fn = `CU_FUNCT_ADD;
      1:       fn = `CU_FUNCT_SUB;
      2:       fn = `CU_FUNCT_AND;
      3:       fn = `CU_FUNCT_XCHG;
      4:       fn = `CU_FUNCT_RTE;
      5:       fn = `CU_FUNCT_BREAK;
      6:       fn = funct_t'($urandom);
      default: begin
        op = opcode_t'($urandom % 63 + 1);
        fn = funct_t'($urandom);
      end
    endcase
  endtask

  task automatic begin_test(input string name);
    cur_tag = cur_tag + 1;
    test_names[cur_tag] = name;
  endtask

  task automatic check(input int tag, input ctrl_word_t expected, input ctrl_word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", test_names[tag], expected, actual);
      test_errs[tag] = test_errs[tag] + 1;
    end
  endtask

  task automatic report_test(input int tag);
    $display("Test %s: %0d cycles checked, %0d mismatches",
             test_names[tag], test_checks[tag], test_errs[tag]);
  endtask

  // Outputs are registered, so sample them away from the rising edge
  always @(negedge clk) begin
    ctrl_word_t actual;
    if (out_valid) begin
      actual.alu   = alu;
      actual.pc    = pc;
      actual.rf    = rf;
      actual.latch = latch;
      check(out_tag, out_exp, actual);
      test_checks[out_tag] = test_checks[out_tag] + 1;
      if (out_last) begin
        report_test(out_tag);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Regression failed");
    $finish;
  end

  initial begin
    int      total_checks;
    int      total_errs;
    opcode_t op;
    funct_t  fn;
    void'($urandom(32'h9ad8812b));
    reset     = 1'b1;
    opcode    = '0;
    funct     = '0;
    // First checked cycle is the all-zero one right after reset
    seq_exp   = '0;
    seq_tag   = 0;
    seq_last  = 1'b0;
    seq_valid = 1'b1;
    out_exp   = '0;
    out_tag   = 0;
    out_last  = 1'b0;
    out_valid = 1'b0;
    cur_tag   = -1;

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;

    begin_test("reset_fetch");
    run_instr(6'h3f, 6'h00, 1'b1);
    begin_test("add");
    run_instr(`CU_OPCODE_RTYPE, `CU_FUNCT_ADD, 1'b1);
    begin_test("sub");
    run_instr(`CU_OPCODE_RTYPE, `CU_FUNCT_SUB, 1'b1);
    begin_test("and");
    run_instr(`CU_OPCODE_RTYPE, `CU_FUNCT_AND, 1'b1);
    begin_test("xchg");
    run_instr(`CU_OPCODE_RTYPE, `CU_FUNCT_XCHG, 1'b1);
    begin_test("rte");
    run_instr(`CU_OPCODE_RTYPE, `CU_FUNCT_RTE, 1'b1);
    begin_test("break");
    run_instr(`CU_OPCODE_RTYPE, `CU_FUNCT_BREAK, 1'b1);
    begin_test("bad_funct");
    run_instr(`CU_OPCODE_RTYPE, 6'h3a, 1'b1);
    begin_test("bad_opcode");
    run_instr(6'h23, `CU_FUNCT_ADD, 1'b1);
    begin_test("random");
    for (int n = 0; n < RANDOM_INSTRS; n++) begin
      pick_random_instr(op, fn);
      run_instr(op, fn, n == RANDOM_INSTRS - 1);
    end

    // Move the final expected word to the output stage, then stop comparing
    push_cycle('0, cur_tag, 1'b0, 1'b0);
    @(posedge clk);
    push_cycle('0, cur_tag, 1'b0, 1'b0);
    @(negedge clk);

    total_checks = 0;
    total_errs   = 0;
    for (int t = 0; t <= cur_tag; t++) begin
      total_checks = total_checks + test_checks[t];
      total_errs   = total_errs + test_errs[t];
    end
    if (total_checks == 0) begin
      $display("No output cycle was compared");
      total_errs = total_errs + 1;
    end
    $display("Tests: %0d, cycles checked: %0d, mismatches: %0d",
             cur_tag + 1, total_checks, total_errs);
    if (total_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
source/cu_pkg.sv
source/cu_decoder.sv
source/cu_sequencer.sv
source/cu_control_table.sv
source/control_unit.sv
dv/control_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build the control unit testbench with Verilator and run it.
# The run counts as passed only if the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module control_unit_tb \
  && ./obj_dir/Vcontrol_unit_tb | tee /dev/stderr | grep -q "Regression passed" \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
